/* Bender.yml */
package:
  name: lc4_core

sources:
  - files:
      - logic/lc4_pkg.sv
      - logic/lc4_fwd_if.sv
      - logic/lc4_decoder.sv
      - logic/lc4_regfile.sv
      - logic/lc4_alu.sv
      - logic/lc4_hazard_unit.sv
      - logic/lc4_pc_unit.sv
      - logic/lc4_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_lc4_core.sv

/* compile.f */
+incdir+include
logic/lc4_pkg.sv
logic/lc4_fwd_if.sv
logic/lc4_decoder.sv
logic/lc4_regfile.sv
logic/lc4_alu.sv
logic/lc4_hazard_unit.sv
logic/lc4_pc_unit.sv
logic/lc4_core.sv
tests/tb_lc4_core.sv

/* logic/lc4_alu.sv */
// LC4 execute ALU
// Arithmetic, AND, CONST and the base-plus-offset address of loads and stores

`timescale 1ns/1ps

module lc4_alu
  import lc4_pkg::*;
(
  input  logic [WORD_W-1:0] i_insn,
  input  logic [WORD_W-1:0] i_rs_data,
  input  logic [WORD_W-1:0] i_rt_data,
  output logic [WORD_W-1:0] o_result
);

  opcode_e           op;
  arith_sub_e        sub;
  logic [WORD_W-1:0] imm5;
  logic [WORD_W-1:0] imm6;
  logic [WORD_W-1:0] imm9;

  assign op   = opcode_e'(i_insn[15:12]);
  assign sub  = arith_sub_e'(i_insn[5:3]);
  assign imm5 = {{(WORD_W-5){i_insn[4]}}, i_insn[4:0]};
  assign imm6 = {{(WORD_W-6){i_insn[5]}}, i_insn[5:0]};
  assign imm9 = {{(WORD_W-9){i_insn[8]}}, i_insn[8:0]};

  always_comb begin
    o_result = '0;
    case (op)
      OP_ARITH: begin
        if (i_insn[5]) begin
          o_result = i_rs_data + imm5;
        end else begin
          case (sub)
            ARITH_ADD: o_result = i_rs_data + i_rt_data;
            ARITH_MUL: o_result = i_rs_data * i_rt_data;
            ARITH_SUB: o_result = i_rs_data - i_rt_data;
            default:   o_result = '0;
          endcase
        end
      end
      OP_LOGIC: o_result = i_rs_data & i_rt_data;
      OP_LDR, OP_STR: o_result = i_rs_data + imm6;
      OP_CONST: o_result = imm9;
      default: o_result = '0;
    endcase
  end

endmodule

/* logic/lc4_core.sv */
// LC4 five-stage pipelined core
// Fetch, decode, execute, memory, writeback with full bypassing,
// load-to-use stall and two-slot flush on taken control flow

`timescale 1ns/1ps

module lc4_core
  import lc4_pkg::*;
#(
  parameter logic [WORD_W-1:0] RESET_PC = 16'h8200
) (
  input  logic                 gwe,
  input  logic                 i_arst_n,
  input  logic [WORD_W-1:0]    i_imem_data,
  input  logic [WORD_W-1:0]    i_dmem_data,
  output logic [WORD_W-1:0]    o_imem_addr,
  output logic [WORD_W-1:0]    o_dmem_addr,
  output logic                 o_dmem_we,
  output logic [WORD_W-1:0]    o_dmem_wdata,
  output logic [1:0]           o_wb_stall,
  output logic [WORD_W-1:0]    o_wb_pc,
  output logic [WORD_W-1:0]    o_wb_insn,
  output logic                 o_wb_regfile_we,
  output logic [REG_SEL_W-1:0] o_wb_wsel,
  output logic [WORD_W-1:0]    o_wb_data,
  output logic                 o_wb_nzp_we,
  output nzp_t                 o_wb_nzp
);

  stage_ctl_t        dec_ctl, d_next, x_next;
  stage_ctl_t        d_ctl, x_ctl, m_ctl, w_ctl;
  logic [WORD_W-1:0] rf_rs, rf_rt, x_rs, x_rt, rs_val, rt_val, alu_out;
  logic [WORD_W-1:0] m_result, m_rt, w_result, w_load;
  logic              m_st_wm, load_use, flush;
  logic              rs_mx, rs_wx, rt_mx, rt_wx, st_wm;

  lc4_fwd_if fwd ();

  assign fwd.m_wsel    = m_ctl.wsel;
  assign fwd.m_we      = m_ctl.regfile_we;
  assign fwd.m_is_load = m_ctl.is_load;
  assign fwd.m_stall   = m_ctl.stall;
  assign fwd.w_wsel    = w_ctl.wsel;
  assign fwd.w_we      = w_ctl.regfile_we;
  assign fwd.w_stall   = w_ctl.stall;

  lc4_pc_unit #(.RESET_PC(RESET_PC)) u_pc (
    .gwe(gwe), .i_arst_n(i_arst_n), .i_stall(load_use), .i_x_ctl(x_ctl),
    .i_m_result(m_result), .i_m_nzp_we(m_ctl.nzp_we), .i_w_nzp_we(w_ctl.nzp_we),
    .i_w_nzp(o_wb_nzp), .o_pc(o_imem_addr), .o_flush(flush), .o_nzp()
  );

  lc4_decoder u_dec (.i_insn(i_imem_data), .i_pc(o_imem_addr), .o_ctl(dec_ctl));

  lc4_regfile u_rf (
    .gwe(gwe), .i_arst_n(i_arst_n), .i_rs_sel(d_ctl.rs_sel), .i_rt_sel(d_ctl.rt_sel),
    .i_wsel(w_ctl.wsel), .i_we(w_ctl.regfile_we), .i_wdata(o_wb_data),
    .o_rs_data(rf_rs), .o_rt_data(rf_rt)
  );

  lc4_hazard_unit u_hz (
    .i_d_ctl(d_ctl), .i_x_ctl(x_ctl), .fwd(fwd), .o_load_use_stall(load_use),
    .o_rs_sel_mx(rs_mx), .o_rs_sel_wx(rs_wx), .o_rt_sel_mx(rt_mx),
    .o_rt_sel_wx(rt_wx), .o_st_sel_wm(st_wm)
  );

  // Operand selection in execute
  assign rs_val = rs_mx ? m_result : (rs_wx ? o_wb_data : x_rs);
  assign rt_val = rt_mx ? m_result : (rt_wx ? o_wb_data : x_rt);

  lc4_alu u_alu (.i_insn(x_ctl.insn), .i_rs_data(rs_val), .i_rt_data(rt_val), .o_result(alu_out));

  // Decode holds on a stall, execute takes a load-use bubble
  always_comb begin
    d_next = flush ? BUBBLE : (load_use ? d_ctl : dec_ctl);
    x_next = d_ctl;
    if (flush) begin
      x_next = BUBBLE;
    end else if (load_use) begin
      x_next       = BUBBLE;
      x_next.stall = STALL_LOAD_USE;
    end
  end

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      d_ctl   <= BUBBLE;
      x_ctl   <= BUBBLE;
      m_ctl   <= BUBBLE;
      w_ctl   <= BUBBLE;
      m_st_wm <= 1'b0;
    end else begin
      d_ctl   <= d_next;
      x_ctl   <= x_next;
      m_ctl   <= x_ctl;
      w_ctl   <= m_ctl;
      m_st_wm <= st_wm;
    end
  end

  always_ff @(posedge gwe) begin
    x_rs     <= rf_rs;
    x_rt     <= rf_rt;
    m_result <= alu_out;
    m_rt     <= rt_val;
    w_result <= m_result;
    w_load   <= i_dmem_data;
  end

  // Memory stage
  assign o_dmem_addr  = (m_ctl.is_load || m_ctl.is_store) ? m_result : '0;
  assign o_dmem_we    = m_ctl.is_store;
  assign o_dmem_wdata = m_st_wm ? o_wb_data : m_rt;

  // Writeback trace
  assign o_wb_data       = w_ctl.is_load ? w_load : w_result;
  assign o_wb_nzp        = nzp_of(o_wb_data);
  assign o_wb_stall      = w_ctl.stall;
  assign o_wb_pc         = w_ctl.pc;
  assign o_wb_insn       = w_ctl.insn;
  assign o_wb_regfile_we = w_ctl.regfile_we;
  assign o_wb_wsel       = w_ctl.wsel;
  assign o_wb_nzp_we     = w_ctl.nzp_we;

  a_no_store_on_load: assert property (@(posedge gwe) disable iff (!i_arst_n)
    !(o_dmem_we && m_ctl.is_load))
    else $error("Data memory write during a load");

endmodule

/* logic/lc4_decoder.sv */
// LC4 instruction decoder
// Builds the stage control record from a fetched instruction word

`timescale 1ns/1ps

module lc4_decoder
  import lc4_pkg::*;
(
  input  logic [WORD_W-1:0] i_insn,
  input  logic [WORD_W-1:0] i_pc,
  output stage_ctl_t        o_ctl
);

  opcode_e    op;
  arith_sub_e sub;

  assign op  = opcode_e'(i_insn[15:12]);
  assign sub = arith_sub_e'(i_insn[5:3]);

  always_comb begin
    o_ctl        = '0;
    o_ctl.pc     = i_pc;
    o_ctl.insn   = i_insn;
    o_ctl.rs_sel = i_insn[8:6];
    o_ctl.rt_sel = i_insn[2:0];
    o_ctl.wsel   = i_insn[11:9];
    o_ctl.stall  = STALL_NONE;
    case (op)
      // BR with no condition bits is the canonical NOP
      OP_BR: o_ctl.is_branch = |i_insn[11:9];
      OP_ARITH: begin
        if (i_insn[5] || sub inside {ARITH_ADD, ARITH_MUL, ARITH_SUB}) begin
          o_ctl.rs_used    = 1'b1;
          o_ctl.rt_used    = !i_insn[5];
          o_ctl.regfile_we = 1'b1;
          o_ctl.nzp_we     = 1'b1;
        end
      end
      OP_LOGIC: begin
        // Only the register AND is supported
        if (i_insn[5:3] == 3'b000) begin
          o_ctl.rs_used    = 1'b1;
          o_ctl.rt_used    = 1'b1;
          o_ctl.regfile_we = 1'b1;
          o_ctl.nzp_we     = 1'b1;
        end
      end
      OP_LDR: begin
        o_ctl.rs_used    = 1'b1;
        o_ctl.regfile_we = 1'b1;
        o_ctl.nzp_we     = 1'b1;
        o_ctl.is_load    = 1'b1;
      end
      OP_STR: begin
        // Store data register sits in the destination field
        o_ctl.rt_sel   = i_insn[11:9];
        o_ctl.rs_used  = 1'b1;
        o_ctl.rt_used  = 1'b1;
        o_ctl.is_store = 1'b1;
      end
      OP_CONST: begin
        o_ctl.regfile_we = 1'b1;
        o_ctl.nzp_we     = 1'b1;
      end
      OP_JMP: o_ctl.is_jump = i_insn[11];
      default: ;
    endcase
  end

endmodule

/* logic/lc4_fwd_if.sv */
// LC4 forwarding interface
// Destinations of the memory and writeback stages, sent back to the
// hazard unit every cycle

`timescale 1ns/1ps

interface lc4_fwd_if
  import lc4_pkg::*;
();

  // Memory stage
  logic [REG_SEL_W-1:0] m_wsel;
  logic                 m_we;
  logic                 m_is_load;
  stall_e               m_stall;

  // Writeback stage
  logic [REG_SEL_W-1:0] w_wsel;
  logic                 w_we;
  stall_e               w_stall;

  modport src  (output m_wsel, m_we, m_is_load, m_stall, w_wsel, w_we, w_stall);
  modport sink (input  m_wsel, m_we, m_is_load, m_stall, w_wsel, w_we, w_stall);

endinterface

/* logic/lc4_hazard_unit.sv */
// LC4 hazard unit
// Load-to-use stall detection and bypass selects for the execute operands
// and the store data of the memory stage

`timescale 1ns/1ps

module lc4_hazard_unit
  import lc4_pkg::*;
(
  input  stage_ctl_t  i_d_ctl,
  input  stage_ctl_t  i_x_ctl,
  lc4_fwd_if.sink     fwd,
  output logic        o_load_use_stall,
  output logic        o_rs_sel_mx,
  output logic        o_rs_sel_wx,
  output logic        o_rt_sel_mx,
  output logic        o_rt_sel_wx,
  output logic        o_st_sel_wm
);

  logic m_valid;
  logic w_valid;
  logic rs_hit_m;
  logic rt_hit_m;
  logic rs_hit_w;
  logic rt_hit_w;

  // Branches also wait on a load because the load sets NZP late
  assign o_load_use_stall = i_x_ctl.is_load &&
                            ((i_d_ctl.rs_used && i_x_ctl.wsel == i_d_ctl.rs_sel) ||
                             (i_d_ctl.rt_used && i_x_ctl.wsel == i_d_ctl.rt_sel) ||
                             i_d_ctl.is_branch);

  assign m_valid = fwd.m_we && fwd.m_stall == STALL_NONE;
  assign w_valid = fwd.w_we && fwd.w_stall == STALL_NONE;

  assign rs_hit_m = m_valid && i_x_ctl.rs_used && fwd.m_wsel == i_x_ctl.rs_sel;
  assign rt_hit_m = m_valid && i_x_ctl.rt_used && fwd.m_wsel == i_x_ctl.rt_sel;
  assign rs_hit_w = w_valid && i_x_ctl.rs_used && fwd.w_wsel == i_x_ctl.rs_sel;
  assign rt_hit_w = w_valid && i_x_ctl.rt_used && fwd.w_wsel == i_x_ctl.rt_sel;

  // Memory stage is younger, so it wins over writeback
  assign o_rs_sel_mx = rs_hit_m;
  assign o_rt_sel_mx = rt_hit_m;
  assign o_rs_sel_wx = rs_hit_w && !rs_hit_m;
  assign o_rt_sel_wx = rt_hit_w && !rt_hit_m;

  // Store data produced by the load now in memory; picked up one cycle later
  // from writeback, so the core registers this select alongside the store
  assign o_st_sel_wm = i_x_ctl.is_store && fwd.m_is_load && rt_hit_m;

  // A load result is never forwarded from memory to execute
  a_mx_not_load: assert final (!((o_rs_sel_mx || o_rt_sel_mx) && fwd.m_is_load))
    else $error("MX bypass selected a load in the memory stage");

endmodule

/* logic/lc4_pc_unit.sv */
// LC4 next-PC unit
// PC and NZP registers, NZP bypass to execute, branch and jump resolution

`timescale 1ns/1ps

module lc4_pc_unit
  import lc4_pkg::*;
#(
  parameter logic [WORD_W-1:0] RESET_PC = 16'h8200
) (
  input  logic              gwe,
  input  logic              i_arst_n,
  input  logic              i_stall,
  input  stage_ctl_t        i_x_ctl,
  input  logic [WORD_W-1:0] i_m_result,
  input  logic              i_m_nzp_we,
  input  logic              i_w_nzp_we,
  input  nzp_t              i_w_nzp,
  output logic [WORD_W-1:0] o_pc,
  output logic              o_flush,
  output nzp_t              o_nzp
);

  logic [WORD_W-1:0] offset;
  logic [WORD_W-1:0] target;
  logic [WORD_W-1:0] next_pc;
  nzp_t              x_nzp;
  logic              br_taken;

  // Youngest producer first
  assign x_nzp = i_m_nzp_we ? nzp_of(i_m_result) : (i_w_nzp_we ? i_w_nzp : o_nzp);

  assign br_taken = i_x_ctl.is_branch && |(i_x_ctl.insn[11:9] & x_nzp);
  assign o_flush  = br_taken || i_x_ctl.is_jump;

  assign offset  = i_x_ctl.is_jump ? {{(WORD_W-11){i_x_ctl.insn[10]}}, i_x_ctl.insn[10:0]}
                                   : {{(WORD_W-9){i_x_ctl.insn[8]}}, i_x_ctl.insn[8:0]};
  assign target  = i_x_ctl.pc + WORD_W'(1) + offset;
  assign next_pc = o_flush ? target : o_pc + WORD_W'(1);

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_pc <= RESET_PC;
    end else if (!i_stall) begin
      o_pc <= next_pc;
    end
  end

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_nzp <= '0;
    end else if (i_w_nzp_we) begin
      o_nzp <= i_w_nzp;
    end
  end

  // The resolving instruction in execute is never a load, so no overlap
  a_flush_no_stall: assert property (@(posedge gwe) disable iff (!i_arst_n)
    !(o_flush && i_stall))
    else $error("Flush and load-use stall in the same cycle");

endmodule

/* logic/lc4_pkg.sv */
// LC4 pipeline package
// ISA widths, opcode and stall encodings, the per-stage control record
// and the condition-code helper shared by the pipeline blocks

package lc4_pkg;

  localparam int WORD_W    = 16;
  localparam int REG_SEL_W = 3;

  // Top nibble of the instruction word
  typedef enum logic [3:0] {
    OP_BR    = 4'b0000,
    OP_ARITH = 4'b0001,
    OP_LOGIC = 4'b0101,
    OP_LDR   = 4'b0110,
    OP_STR   = 4'b0111,
    OP_CONST = 4'b1001,
    OP_JMP   = 4'b1100
  } opcode_e;

  // Register-form arithmetic sub-opcodes, insn[5:3]
  typedef enum logic [2:0] {
    ARITH_ADD = 3'b000,
    ARITH_MUL = 3'b001,
    ARITH_SUB = 3'b010
  } arith_sub_e;

  // Commit status reported at writeback
  typedef enum logic [1:0] {
    STALL_NONE     = 2'd0,
    STALL_FLUSH    = 2'd2,
    STALL_LOAD_USE = 2'd3
  } stall_e;

  typedef logic [2:0] nzp_t;

  typedef struct packed {
    logic [WORD_W-1:0]    pc;
    logic [WORD_W-1:0]    insn;
    logic [REG_SEL_W-1:0] rs_sel;
    logic [REG_SEL_W-1:0] rt_sel;
    logic [REG_SEL_W-1:0] wsel;
    logic                 rs_used;
    logic                 rt_used;
    logic                 regfile_we;
    logic                 nzp_we;
    logic                 is_load;
    logic                 is_store;
    logic                 is_branch;
    logic                 is_jump;
    stall_e               stall;
  } stage_ctl_t;

  // Empty slot injected on a flush
  localparam stage_ctl_t BUBBLE = '{stall: STALL_FLUSH, default: '0};

  // Signed sign of a result as n/z/p
  function automatic nzp_t nzp_of(input logic [WORD_W-1:0] value);
    if (value[WORD_W-1]) begin
      return 3'b100;
    end
    if (value == '0) begin
      return 3'b010;
    end
    return 3'b001;
  endfunction

endpackage

/* logic/lc4_regfile.sv */
// LC4 register file
// Eight 16-bit registers, two combinational read ports, one write port,
// with same-cycle write-through on both reads

`timescale 1ns/1ps

module lc4_regfile
  import lc4_pkg::*;
(
  input  logic                 gwe,
  input  logic                 i_arst_n,
  input  logic [REG_SEL_W-1:0] i_rs_sel,
  input  logic [REG_SEL_W-1:0] i_rt_sel,
  input  logic [REG_SEL_W-1:0] i_wsel,
  input  logic                 i_we,
  input  logic [WORD_W-1:0]    i_wdata,
  output logic [WORD_W-1:0]    o_rs_data,
  output logic [WORD_W-1:0]    o_rt_data
);

  localparam int NUM_REGS = 1 << REG_SEL_W;

  logic [WORD_W-1:0] regs [NUM_REGS];

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_wsel] <= i_wdata;
    end
  end

  // WD bypass
  assign o_rs_data = (i_we && i_wsel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
  assign o_rt_data = (i_we && i_wsel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

endmodule

/* include/tb_program.svh */
// LC4 core test program
// Program image, initial data word and the expected commit sequence

`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int          NUM_ROWS = 22;
localparam logic [15:0] BASE_PC  = 16'h8200;

typedef struct {
  int          stall;
  logic [15:0] pc_off;
  logic        we;
  logic [2:0]  wsel;
  logic [15:0] data;
  logic [2:0]  nzp;
  logic        st;
  logic [15:0] st_addr;
  logic [15:0] st_data;
} commit_t;

commit_t expect_tbl [NUM_ROWS];
int      row_fill;

task automatic add_row(input int stall, input int pc_off, input logic we,
                       input logic [2:0] wsel, input logic [15:0] data,
                       input logic [2:0] nzp);
  expect_tbl[row_fill] = '{stall, pc_off[15:0], we, wsel, data, nzp, 1'b0, 16'h0, 16'h0};
  row_fill++;
endtask

task automatic mark_store(input logic [15:0] addr, input logic [15:0] value);
  expect_tbl[row_fill-1].st      = 1'b1;
  expect_tbl[row_fill-1].st_addr = addr;
  expect_tbl[row_fill-1].st_data = value;
endtask

task automatic load_program();
  logic [15:0] words [20];
  words = '{16'h9205, 16'h95FD, 16'h1642, 16'h18D1, 16'h1B0A,
            16'h5D41, 16'h1FBE, 16'h620A, 16'h1443, 16'h7414,
            16'h163F, 16'h0802, 16'h9807, 16'h9808, 16'h0401,
            16'h9A09, 16'hC801, 16'h9BFF, 16'h1D45, 16'h5E06};
  for (int i = 0; i < 20; i++) begin
    imem[BASE_PC + i] = words[i];
  end
  dmem[10] = 16'h0123;
  row_fill = 0;
  // ALU chain
  add_row(0, 0, 1, 1, 16'h0005, 3'b001);
  add_row(0, 1, 1, 2, 16'hFFFD, 3'b100);
  add_row(0, 2, 1, 3, 16'h0002, 3'b001);
  add_row(0, 3, 1, 4, 16'hFFFD, 3'b100);
  add_row(0, 4, 1, 5, 16'h0009, 3'b001);
  add_row(0, 5, 1, 6, 16'h0001, 3'b001);
  add_row(0, 6, 1, 7, 16'hFFFF, 3'b100);
  // Load, stall, dependent add, store
  add_row(0, 7, 1, 1, 16'h0123, 3'b001);
  add_row(3, 0, 0, 0, 16'h0000, 3'b000);
  add_row(0, 8, 1, 2, 16'h0125, 3'b001);
  add_row(0, 9, 0, 0, 16'h0000, 3'b000);
  mark_store(16'h0014, 16'h0125);
  // Taken BRn, not-taken BRz, JMP
  add_row(0, 10, 1, 3, 16'hFFFF, 3'b100);
  add_row(0, 11, 0, 0, 16'h0000, 3'b000);
  add_row(2, 0, 0, 0, 16'h0000, 3'b000);
  add_row(2, 0, 0, 0, 16'h0000, 3'b000);
  add_row(0, 14, 0, 0, 16'h0000, 3'b000);
  add_row(0, 15, 1, 5, 16'h0009, 3'b001);
  add_row(0, 16, 0, 0, 16'h0000, 3'b000);
  add_row(2, 0, 0, 0, 16'h0000, 3'b000);
  add_row(2, 0, 0, 0, 16'h0000, 3'b000);
  add_row(0, 18, 1, 6, 16'h0012, 3'b001);
  add_row(0, 19, 1, 7, 16'h0000, 3'b010);
endtask

`endif

/* tests/tb_lc4_core.sv */
// LC4 core testbench
// Runs a short program through the pipeline and checks every writeback
// commit against a table of expected results

`timescale 1ns/1ps

module tb_lc4_core;

  logic        gwe;
  logic        i_arst_n;
  logic [15:0] i_imem_data;
  logic [15:0] i_dmem_data;
  logic [15:0] o_imem_addr;
  logic [15:0] o_dmem_addr;
  logic        o_dmem_we;
  logic [15:0] o_dmem_wdata;
  logic [1:0]  o_wb_stall;
  logic [15:0] o_wb_pc;
  logic [15:0] o_wb_insn;
  logic        o_wb_regfile_we;
  logic [2:0]  o_wb_wsel;
  logic [15:0] o_wb_data;
  logic        o_wb_nzp_we;
  logic [2:0]  o_wb_nzp;

  logic [15:0] imem [0:65535];
  logic [15:0] dmem [0:65535];
  logic [15:0] last_st_addr;
  logic [15:0] last_st_data;
  int          pass_count;
  int          fail_count;
  bit          row_bad;

  `include "tb_program.svh"

  lc4_core #(.RESET_PC(16'h8200)) i_dut (
    .gwe(gwe), .i_arst_n(i_arst_n), .i_imem_data(i_imem_data),
    .i_dmem_data(i_dmem_data), .o_imem_addr(o_imem_addr), .o_dmem_addr(o_dmem_addr),
    .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata), .o_wb_stall(o_wb_stall),
    .o_wb_pc(o_wb_pc), .o_wb_insn(o_wb_insn), .o_wb_regfile_we(o_wb_regfile_we),
    .o_wb_wsel(o_wb_wsel), .o_wb_data(o_wb_data), .o_wb_nzp_we(o_wb_nzp_we),
    .o_wb_nzp(o_wb_nzp)
  );

  always #5 gwe = ~gwe;

  // Memories answer 1 ns after each edge, addresses are stable until the next one
  always @(posedge gwe) begin
    #1;
    i_imem_data = imem[o_imem_addr];
    i_dmem_data = dmem[o_dmem_addr];
  end

  always @(negedge gwe) begin
    if (i_arst_n && o_dmem_we) begin
      dmem[o_dmem_addr] = o_dmem_wdata;
      last_st_addr      = o_dmem_addr;
      last_st_data      = o_dmem_wdata;
    end
  end

  task automatic check_val(input string name, input logic [15:0] got,
                           input logic [15:0] exp);
    assert (got === exp) else begin
      $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
      row_bad = 1'b1;
    end
  endtask

  task automatic finish_test(input string label);
    if (row_bad) begin
      fail_count++;
      $display("%s: FAIL", label);
    end else begin
      pass_count++;
      $display("%s: ok", label);
    end
  endtask

  // Watchdog sized from the table length
  initial begin
    #((NUM_ROWS * 6 + 50) * 10);
    $display("Timeout: the pipeline did not finish the expected commits in time");
    $display("Test failed");
    $finish;
  end

  initial begin
    commit_t e;
    gwe         = 1'b0;
    i_arst_n    = 1'b0;
    i_imem_data = 16'h0000;
    i_dmem_data = 16'h0000;
    pass_count  = 0;
    fail_count  = 0;
    void'($urandom(57041));
    for (int a = 0; a < 65536; a++) begin
      imem[a] = 16'h0000;
      dmem[a] = $urandom();
    end
    load_program();

    repeat (5) @(posedge gwe);
    #1 i_arst_n = 1'b1;
    @(negedge gwe);
    row_bad = 1'b0;
    check_val("o_imem_addr", o_imem_addr, 16'h8200);
    check_val("o_wb_regfile_we", o_wb_regfile_we, 1'b0);
    check_val("o_wb_nzp_we", o_wb_nzp_we, 1'b0);
    check_val("o_dmem_we", o_dmem_we, 1'b0);
    check_val("o_wb_stall", o_wb_stall, 2'd2);
    finish_test("reset");

    // Skip the reset bubbles
    while (o_wb_stall == 2'd2) begin
      @(negedge gwe);
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      if (r > 0) begin
        @(negedge gwe);
      end
      e       = expect_tbl[r];
      row_bad = 1'b0;
      check_val("o_wb_stall", o_wb_stall, e.stall[1:0]);
      check_val("o_wb_regfile_we", o_wb_regfile_we, e.we);
      check_val("o_wb_nzp_we", o_wb_nzp_we, e.we);
      if (e.stall == 0) begin
        check_val("o_wb_pc", o_wb_pc, BASE_PC + e.pc_off);
        check_val("o_wb_insn", o_wb_insn, imem[BASE_PC + e.pc_off]);
      end
      if (e.we) begin
        check_val("o_wb_wsel", o_wb_wsel, e.wsel);
        check_val("o_wb_data", o_wb_data, e.data);
        check_val("o_wb_nzp", o_wb_nzp, e.nzp);
      end
      if (e.st) begin
        check_val("o_dmem_addr", last_st_addr, e.st_addr);
        check_val("o_dmem_wdata", last_st_data, e.st_data);
        check_val("dmem", dmem[e.st_addr], e.st_data);
      end
      finish_test($sformatf("commit %0d stall %0d", r, e.stall));
    end

    $display("Checks done: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
